// File: Makefile
VERILATOR := verilator
TOP       := armCoreTb
FILELIST  := verilog.f
OBJDIR    := obj_dir
LINTFLAGS := --lint-only --timing --assert
SIMFLAGS  := --binary --timing --assert -Mdir $(OBJDIR)
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: common/armPkg.sv
/* Shared types for the ARM-style core: word, register, flag and opcode
   types, operand and shift enums, and core-wide constants */
package armPkg;

  typedef logic [31:0] dataT;     // Instruction, address or operand word
  typedef logic [3:0]  regAddrT;  // Register number
  typedef logic [3:0]  flagsT;    // N Z C V from MSB down

  // Data-processing opcodes in instruction encoding order
  typedef enum logic [3:0] {
    aluAnd = 4'h0,
    aluEor = 4'h1,
    aluSub = 4'h2,
    aluRsb = 4'h3,
    aluAdd = 4'h4,
    aluAdc = 4'h5,
    aluSbc = 4'h6,
    aluRsc = 4'h7,
    aluTst = 4'h8,
    aluTeq = 4'h9,
    aluCmp = 4'ha,
    aluCmn = 4'hb,
    aluOrr = 4'hc,
    aluMov = 4'hd,
    aluBic = 4'he,
    aluMvn = 4'hf
  } aluOpT;

  typedef enum logic [1:0] {
    shLsl = 2'b00,
    shLsr = 2'b01,
    shAsr = 2'b10,
    shRor = 2'b11
  } shiftTypeT;

  typedef enum logic {
    modeImm = 1'b0,  // Rotated 8-bit immediate
    modeReg = 1'b1   // Rm shifted by immediate amount
  } operandModeT;

  localparam regAddrT PcReg    = 4'd15;  // Program counter view
  localparam dataT    NopInstr = '0;     // All-zero NOP

  // Bit positions inside flagsT
  localparam int FlagN = 3;
  localparam int FlagZ = 2;
  localparam int FlagC = 1;
  localparam int FlagV = 0;

endpackage

// File: decode/controlDecoder.sv
/* Control decoder for data-processing instructions, immediate and
   register-shifted-by-immediate forms */
module controlDecoder
  import armPkg::*;
(
  input  dataT        Instr,
  output aluOpT       AluOp,
  output operandModeT Mode,
  output logic        Write,
  output logic        SetFlags,
  output regAddrT     Rd
);

  logic isImmForm;
  logic isRegForm;
  logic supported;
  logic isCompare;

  // Class comes from bits 27:25, bit 4 separates shift by register
  assign isImmForm = (Instr[27:25] == 3'b001);
  assign isRegForm = (Instr[27:25] == 3'b000) && !Instr[4];

  // The all-zero word decodes as AND but retires as a NOP
  assign supported = (isImmForm || isRegForm) && (Instr != NopInstr);

  assign AluOp = aluOpT'(Instr[24:21]);
  assign Mode  = isImmForm ? modeImm : modeReg;
  assign Rd    = Instr[15:12];

  always_comb begin
    unique case (AluOp)
      aluTst, aluTeq, aluCmp, aluCmn: isCompare = 1'b1;  // Flags only
      default:                        isCompare = 1'b0;
    endcase
  end

  assign Write    = supported && !isCompare && (Rd != PcReg);
  assign SetFlags = supported && Instr[20];  // S bit

endmodule

// File: decode/decodeStage.sv
/* Decode stage: control decode, operand read, bubble insertion and
   the decode/execute pipeline register */
module decodeStage
  import armPkg::*;
(
  input  logic        Clk,
  input  logic        Reset,
  input  logic        Hold,
  input  dataT        IdInstr,
  input  dataT        IdPc,
  input  logic        WbEnable,
  input  regAddrT     WbReg,
  input  dataT        WbData,
  output dataT        ExOperandA,
  output dataT        ExRm,
  output logic [11:0] ExImm,
  output operandModeT ExMode,
  output shiftTypeT   ExShiftType,
  output aluOpT       ExAluOp,
  output regAddrT     ExRd,
  output logic        ExWrite,
  output logic        ExSetFlags
);

  aluOpT       idAluOp;
  operandModeT idMode;
  logic        idWrite;
  logic        idSetFlags;
  regAddrT     idRd;
  dataT        rnData;
  dataT        rmData;

  controlDecoder controlDecoder_i (
    .Instr   (IdInstr),
    .AluOp   (idAluOp),
    .Mode    (idMode),
    .Write   (idWrite),
    .SetFlags(idSetFlags),
    .Rd      (idRd)
  );

  registerFile registerFile_i (
    .Clk        (Clk),
    .Reset      (Reset),
    .ReadA      (IdInstr[19:16]),  // Rn
    .ReadB      (IdInstr[3:0]),    // Rm
    .Pc         (IdPc),
    .DataA      (rnData),
    .DataB      (rmData),
    .WriteEnable(WbEnable),
    .WriteReg   (WbReg),
    .WriteData  (WbData)
  );

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      ExOperandA  <= '0;
      ExRm        <= '0;
      ExImm       <= '0;
      ExMode      <= modeImm;
      ExShiftType <= shLsl;
      ExAluOp     <= aluAnd;
      ExRd        <= '0;
      ExWrite     <= 1'b0;
      ExSetFlags  <= 1'b0;
    end else begin
      ExOperandA  <= rnData;
      ExRm        <= rmData;
      ExImm       <= IdInstr[11:0];
      ExMode      <= idMode;
      ExShiftType <= shiftTypeT'(IdInstr[6:5]);
      ExAluOp     <= idAluOp;
      ExRd        <= idRd;
      ExWrite     <= idWrite && !Hold;     // Bubble while fetch is frozen
      ExSetFlags  <= idSetFlags && !Hold;
    end
  end

endmodule

// File: decode/registerFile.sv
/* Register file with sixteen registers, two read ports and one write port */
module registerFile
  import armPkg::*;
(
  input  logic    Clk,
  input  logic    Reset,
  input  regAddrT ReadA,
  input  regAddrT ReadB,
  input  dataT    Pc,
  output dataT    DataA,
  output dataT    DataB,
  input  logic    WriteEnable,
  input  regAddrT WriteReg,
  input  dataT    WriteData
);

  dataT regs [16];
  dataT pcView;

  assign pcView = Pc + 32'd8;  // Fetch runs two words ahead

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (WriteEnable && (WriteReg != PcReg)) begin
      regs[WriteReg] <= WriteData;
    end
  end

  // No write-through, same-cycle reads see the old value
  assign DataA = (ReadA == PcReg) ? pcView : regs[ReadA];
  assign DataB = (ReadB == PcReg) ? pcView : regs[ReadB];

endmodule

// File: execute/aluFlags.sv
/* ALU for the sixteen data-processing opcodes and the NZCV flag register */
module aluFlags
  import armPkg::*;
(
  input  logic  Clk,
  input  logic  Reset,
  input  dataT  A,
  input  dataT  B,
  input  aluOpT AluOp,
  input  logic  SetFlags,
  output dataT  Result,
  output flagsT Flags
);

  dataT        addX;
  dataT        addY;
  logic        addCin;
  logic        isArith;
  logic [32:0] sum;
  dataT        logicResult;
  logic        overflow;

  // Every arithmetic opcode is one adder with chosen inputs
  always_comb begin
    addX    = A;
    addY    = B;
    addCin  = 1'b0;
    isArith = 1'b1;
    unique case (AluOp)
      aluAdd, aluCmn: addCin = 1'b0;
      aluAdc:         addCin = Flags[FlagC];
      aluSub, aluCmp: begin
        addY   = ~B;               // Carry set means no borrow
        addCin = 1'b1;
      end
      aluSbc: begin
        addY   = ~B;
        addCin = Flags[FlagC];
      end
      aluRsb: begin
        addX   = B;
        addY   = ~A;
        addCin = 1'b1;
      end
      aluRsc: begin
        addX   = B;
        addY   = ~A;
        addCin = Flags[FlagC];
      end
      default: isArith = 1'b0;
    endcase
  end

  always_comb begin
    unique case (AluOp)
      aluAnd, aluTst: logicResult = A & B;
      aluEor, aluTeq: logicResult = A ^ B;
      aluOrr:         logicResult = A | B;
      aluMov:         logicResult = B;
      aluBic:         logicResult = A & ~B;
      aluMvn:         logicResult = ~B;
      default:        logicResult = '0;  // Arithmetic opcodes
    endcase
  end

  assign sum      = {1'b0, addX} + {1'b0, addY} + {32'b0, addCin};
  assign overflow = (addX[31] == addY[31]) && (sum[31] != addX[31]);
  assign Result   = isArith ? sum[31:0] : logicResult;

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      Flags <= '0;
    end else if (SetFlags) begin
      Flags[FlagN] <= Result[31];
      Flags[FlagZ] <= (Result == '0);
      if (isArith) begin
        Flags[FlagC] <= sum[32];
        Flags[FlagV] <= overflow;
      end                               // Logical ops keep C and V
    end
  end

endmodule

// File: execute/barrelShifter.sv
/* Barrel shifter for the second operand, rotated immediate or shifted Rm */
module barrelShifter
  import armPkg::*;
(
  input  dataT        Rm,
  input  logic [11:0] Imm,
  input  operandModeT Mode,
  input  shiftTypeT   ShiftType,
  output dataT        Operand
);

  function automatic dataT rotateRight(dataT value, logic [4:0] amount);
    logic [63:0] doubled;
    doubled = {value, value} >> amount;
    return doubled[31:0];
  endfunction

  logic [4:0] immRotate;
  logic [4:0] shiftAmount;

  assign immRotate   = {Imm[11:8], 1'b0};  // Twice the rotate field
  assign shiftAmount = Imm[11:7];

  always_comb begin
    if (Mode == modeImm) begin
      Operand = rotateRight({24'b0, Imm[7:0]}, immRotate);
    end else begin
      unique case (ShiftType)
        shLsl:   Operand = Rm << shiftAmount;
        shLsr:   Operand = Rm >> shiftAmount;
        shAsr:   Operand = dataT'($signed(Rm) >>> shiftAmount);  // Sign fill
        default: Operand = rotateRight(Rm, shiftAmount);
      endcase
    end
  end

endmodule

// File: execute/executeStage.sv
/* Execute stage: shifter, ALU with flags, and the execute/memory and
   memory/write-back pipeline registers */
module executeStage
  import armPkg::*;
(
  input  logic        Clk,
  input  logic        Reset,
  input  dataT        ExOperandA,
  input  dataT        ExRm,
  input  logic [11:0] ExImm,
  input  operandModeT ExMode,
  input  shiftTypeT   ExShiftType,
  input  aluOpT       ExAluOp,
  input  regAddrT     ExRd,
  input  logic        ExWrite,
  input  logic        ExSetFlags,
  output logic        WbEnable,
  output regAddrT     WbReg,
  output dataT        WbData,
  output flagsT       Flags
);

  dataT    operandB;
  dataT    aluResult;
  logic    memWrite;
  regAddrT memRd;
  dataT    memData;

  barrelShifter barrelShifter_i (
    .Rm       (ExRm),
    .Imm      (ExImm),
    .Mode     (ExMode),
    .ShiftType(ExShiftType),
    .Operand  (operandB)
  );

  aluFlags aluFlags_i (
    .Clk     (Clk),
    .Reset   (Reset),
    .A       (ExOperandA),
    .B       (operandB),
    .AluOp   (ExAluOp),
    .SetFlags(ExSetFlags),
    .Result  (aluResult),
    .Flags   (Flags)
  );

  // Memory stage carries the result unchanged
  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      memWrite <= 1'b0;
      memRd    <= '0;
      memData  <= '0;
      WbEnable <= 1'b0;
      WbReg    <= '0;
      WbData   <= '0;
    end else begin
      memWrite <= ExWrite;
      memRd    <= ExRd;
      memData  <= aluResult;
      WbEnable <= memWrite;   // Register file takes it one edge later
      WbReg    <= memRd;
      WbData   <= memData;
    end
  end

endmodule

// File: sim/armCoreTb.sv
/* Core testbench with clock, reset, instruction server, reference
   model, directed tests, watchdog and report */
module armCoreTb
  import armPkg::*;
();

  localparam int   ProgWords      = 64;
  localparam int   NumTests       = 6;
  localparam int   WatchdogCycles = NumTests * ProgWords * 64;
  localparam dataT StartAddr      = 32'h0;

  logic    Clk;
  logic    Reset;
  logic    Hold;
  dataT    InstrAddr;
  dataT    Instr;
  logic    WbEnable;
  regAddrT WbReg;
  dataT    WbData;
  flagsT   Flags;

  dataT    progMem [ProgWords];
  int      progLen;
  dataT    modelRegs [16];
  flagsT   modelFlags;
  regAddrT expReg [$];       // Expected write-back order
  dataT    expData [$];
  regAddrT nextReg;
  dataT    nextData;
  int      errorCount;
  int      errorsAtStart;
  int      passedTests;
  integer  seed;

  armCore #(
    .ResetAddr(StartAddr)
  ) armCore_i (.*);

  // Program memory answers the fetch address and gives NOP past the end
  assign Instr = (InstrAddr[31:8] == '0) ? progMem[InstrAddr[7:2]] : NopInstr;

  always #50 Clk = ~Clk;

  always @(negedge Clk) begin
    if (WbEnable) begin
      if (expReg.size() == 0) begin
        $display("Write-back to register %0d arrived with none expected", WbReg);
        errorCount++;
      end else begin
        nextReg  = expReg.pop_front();
        nextData = expData.pop_front();
        if (WbReg !== nextReg) failValue("WbReg", dataT'(nextReg), dataT'(WbReg));
        if (WbData !== nextData) failValue("WbData", nextData, WbData);
      end
    end
  end

  task automatic failValue(string signalName, dataT expected, dataT actual);
    $display("FAILED %s: expected %h, got %h", signalName, expected, actual);
    errorCount++;
  endtask

  function automatic dataT encodeImm(aluOpT op, logic s, regAddrT rn, regAddrT rd,
                                     logic [3:0] rot, logic [7:0] imm8);
    return {4'he, 3'b001, op, s, rn, rd, rot, imm8};
  endfunction

  function automatic dataT encodeShift(aluOpT op, logic s, regAddrT rn, regAddrT rd,
                                       logic [4:0] amount, shiftTypeT sh, regAddrT rm);
    return {4'he, 3'b000, op, s, rn, rd, amount, sh, 1'b0, rm};
  endfunction

  function automatic dataT rotr(dataT value, logic [4:0] amount);
    return (value >> amount) | (value << (6'd32 - {1'b0, amount}));
  endfunction

  // Returns carry, overflow and the 32-bit result
  function automatic logic [33:0] addSub(dataT x, dataT y, logic subtract, logic carryIn);
    longint ux;
    longint uy;
    longint sx;
    longint sy;
    longint ci;
    longint uRes;
    longint sRes;
    logic   c;
    logic   v;
    ux = longint'(x);
    uy = longint'(y);
    sx = longint'($signed(x));
    sy = longint'($signed(y));
    ci = longint'(carryIn);
    if (subtract) begin
      uRes = ux - uy - (1 - ci);
      sRes = sx - sy - (1 - ci);
      c    = (uRes >= 0);          // No borrow
    end else begin
      uRes = ux + uy + ci;
      sRes = sx + sy + ci;
      c    = (uRes > 64'sh0ffffffff);
    end
    v = (sRes > 64'sh07fffffff) || (sRes < -64'sh080000000);
    return {c, v, uRes[31:0]};
  endfunction

  function automatic dataT readModelReg(regAddrT r, dataT addr);
    return (r == PcReg) ? addr + 32'd8 : modelRegs[r];
  endfunction

  task automatic modelStep(input dataT instr, input dataT addr);
    aluOpT       op;
    regAddrT     rd;
    dataT        a;
    dataT        rm;
    dataT        b;
    dataT        res;
    logic [33:0] arith;
    logic        isArith;
    if (instr == NopInstr) return;
    if (instr[27:25] != 3'b001 && !(instr[27:25] == 3'b000 && !instr[4])) return;
    op      = aluOpT'(instr[24:21]);
    rd      = instr[15:12];
    a       = readModelReg(instr[19:16], addr);
    rm      = readModelReg(instr[3:0], addr);
    arith   = '0;
    isArith = 1'b1;
    if (instr[25]) begin
      b = rotr({24'b0, instr[7:0]}, {instr[11:8], 1'b0});
    end else begin
      case (instr[6:5])
        2'b00:   b = rm << instr[11:7];
        2'b01:   b = rm >> instr[11:7];
        2'b10:   b = dataT'($signed(rm) >>> instr[11:7]);
        default: b = rotr(rm, instr[11:7]);
      endcase
    end
    case (op)
      aluSub, aluCmp: arith = addSub(a, b, 1'b1, 1'b1);
      aluRsb:         arith = addSub(b, a, 1'b1, 1'b1);
      aluAdd, aluCmn: arith = addSub(a, b, 1'b0, 1'b0);
      aluAdc:         arith = addSub(a, b, 1'b0, modelFlags[FlagC]);
      aluSbc:         arith = addSub(a, b, 1'b1, modelFlags[FlagC]);
      aluRsc:         arith = addSub(b, a, 1'b1, modelFlags[FlagC]);
      default:        isArith = 1'b0;
    endcase
    case (op)
      aluAnd, aluTst: res = a & b;
      aluEor, aluTeq: res = a ^ b;
      aluOrr:         res = a | b;
      aluMov:         res = b;
      aluBic:         res = a & ~b;
      aluMvn:         res = ~b;
      default:        res = arith[31:0];
    endcase
    if (instr[20]) begin
      modelFlags[FlagN] = res[31];
      modelFlags[FlagZ] = (res == '0);
      if (isArith) modelFlags[FlagC:FlagV] = arith[33:32];
    end
    if (!(op inside {aluTst, aluTeq, aluCmp, aluCmn}) && rd != PcReg) begin
      modelRegs[rd] = res;
      expReg.push_back(rd);
      expData.push_back(res);
    end
  endtask

  task automatic clearProgram();
    for (int i = 0; i < ProgWords; i++) progMem[i] = NopInstr;
    progLen = 0;
    errorsAtStart = errorCount;
  endtask

  // Three NOPs follow each instruction so results reach the register file
  task automatic addInstr(dataT instr);
    progMem[progLen] = instr;
    progLen += 4;
  endtask

  task automatic loadWord(regAddrT rd, dataT value);
    addInstr(encodeImm(aluMov, 1'b0, 4'd0, rd, 4'd0, value[7:0]));
    addInstr(encodeImm(aluOrr, 1'b0, rd, rd, 4'd12, value[15:8]));   // Byte to 15:8
    addInstr(encodeImm(aluOrr, 1'b0, rd, rd, 4'd8, value[23:16]));
    addInstr(encodeImm(aluOrr, 1'b0, rd, rd, 4'd4, value[31:24]));
  endtask

  task automatic buildModel();
    for (int r = 0; r < 16; r++) modelRegs[r] = '0;
    modelFlags = '0;
    expReg.delete();
    expData.delete();
    for (int i = 0; i < progLen; i++) modelStep(progMem[i], StartAddr + 32'(i * 4));
  endtask

  task automatic resetCore();
    @(negedge Clk);
    Reset = 1'b1;
    Hold  = 1'b0;
    repeat (10) @(negedge Clk);
    Reset = 1'b0;
  endtask

  task automatic drainAndCheck();
    // Last write-back lands four edges after its capture
    while (InstrAddr < StartAddr + 32'((progLen + 5) * 4)) @(negedge Clk);
    if (expReg.size() != 0) begin
      $display("%0d expected write-backs never appeared", expReg.size());
      errorCount++;
      expReg.delete();
      expData.delete();
    end
    if (Flags !== modelFlags) failValue("Flags", dataT'(modelFlags), dataT'(Flags));
  endtask

  task automatic reportTest(string name);
    if (errorCount == errorsAtStart) begin
      passedTests++;
      $display("%-22s passed", name);
    end else begin
      $display("%-22s %0d errors", name, errorCount - errorsAtStart);
    end
  endtask

  task automatic immediateProgram();
    addInstr(encodeImm(aluMov, 1'b0, 4'd0, 4'd1, 4'd0, 8'hff));
    addInstr(encodeImm(aluMov, 1'b0, 4'd0, 4'd2, 4'd4, 8'h3f));   // 0x3f000000
    addInstr(encodeImm(aluAdd, 1'b0, 4'd1, 4'd3, 4'd0, 8'h10));
    addInstr(encodeImm(aluOrr, 1'b0, 4'd2, 4'd4, 4'd12, 8'hab));
    addInstr(encodeImm(aluEor, 1'b0, 4'd3, 4'd5, 4'd0, 8'h0f));
    addInstr(encodeImm(aluBic, 1'b0, 4'd1, 4'd6, 4'd0, 8'h0f));
    addInstr(encodeImm(aluMvn, 1'b0, 4'd0, 4'd7, 4'd0, 8'h00));
  endtask

  task automatic testResetState();
    clearProgram();
    progLen = 8;
    buildModel();
    resetCore();
    if (InstrAddr !== StartAddr) failValue("InstrAddr", StartAddr, InstrAddr);
    if (Flags !== 4'h0) failValue("Flags", 32'h0, dataT'(Flags));
    if (WbEnable !== 1'b0) failValue("WbEnable", 32'h0, dataT'(WbEnable));
    drainAndCheck();
    reportTest("reset state");
  endtask

  task automatic testImmediate();
    clearProgram();
    immediateProgram();
    buildModel();
    resetCore();
    drainAndCheck();
    reportTest("immediate operations");
  endtask

  task automatic testRegisterShifts();
    dataT wordA;
    dataT wordB;
    clearProgram();
    wordA = $random(seed);
    wordB = $random(seed);
    loadWord(4'd1, wordA);
    loadWord(4'd2, wordB);
    addInstr(encodeShift(aluMov, 1'b0, 4'd0, 4'd3, 5'($random(seed)), shLsl, 4'd1));
    addInstr(encodeShift(aluAdd, 1'b0, 4'd3, 4'd4, 5'($random(seed)), shLsr, 4'd2));
    addInstr(encodeShift(aluSub, 1'b0, 4'd4, 4'd5, 5'($random(seed)), shAsr, 4'd1));
    addInstr(encodeShift(aluEor, 1'b0, 4'd5, 4'd6, 5'($random(seed)), shRor, 4'd2));
    buildModel();
    resetCore();
    drainAndCheck();
    reportTest("register shifts");
  endtask

  task automatic testFlags();
    clearProgram();
    addInstr(encodeImm(aluMov, 1'b0, 4'd0, 4'd1, 4'd1, 8'h02));          // 0x80000000
    addInstr(encodeShift(aluAdd, 1'b1, 4'd1, 4'd2, 5'd0, shLsl, 4'd1));  // Zero, C and V
    addInstr(encodeImm(aluAdc, 1'b0, 4'd1, 4'd3, 4'd0, 8'h01));
    addInstr(encodeImm(aluSub, 1'b1, 4'd1, 4'd4, 4'd0, 8'h01));
    addInstr(encodeImm(aluCmp, 1'b1, 4'd1, 4'd0, 4'd1, 8'h02));
    addInstr(encodeImm(aluCmn, 1'b1, 4'd1, 4'd0, 4'd0, 8'h01));
    addInstr(encodeImm(aluTst, 1'b1, 4'd1, 4'd0, 4'd0, 8'h01));
    addInstr(encodeImm(aluSbc, 1'b1, 4'd1, 4'd5, 4'd0, 8'h00));
    buildModel();
    resetCore();
    drainAndCheck();
    reportTest("flags");
  endtask

  task automatic testHold();
    dataT heldAddr;
    clearProgram();
    immediateProgram();
    buildModel();
    resetCore();
    repeat (9) @(negedge Clk);
    heldAddr = StartAddr + 32'(9 * 4);  // Nine words fetched since reset
    Hold     = 1'b1;                 // ADD sits in decode here
    repeat (5) begin
      @(negedge Clk);
      if (InstrAddr !== heldAddr) failValue("InstrAddr", heldAddr, InstrAddr);
    end
    Hold = 1'b0;
    drainAndCheck();
    reportTest("hold");
  endtask

  task automatic testPcAndUnsupported();
    clearProgram();
    addInstr(encodeImm(aluMov, 1'b0, 4'd0, 4'd2, 4'd0, 8'h55));
    addInstr(encodeImm(aluCmp, 1'b1, 4'd2, 4'd0, 4'd0, 8'h55));          // Sets Z and C
    addInstr(encodeShift(aluMov, 1'b0, 4'd0, 4'd1, 5'd0, shLsl, PcReg));
    addInstr(encodeImm(aluMov, 1'b0, 4'd0, PcReg, 4'd0, 8'h04));
    addInstr(32'he5912000);                                              // Load word
    addInstr(32'hea000010);                                              // Branch
    buildModel();
    resetCore();
    drainAndCheck();
    reportTest("r15 and unsupported");
  endtask

  initial begin
    Clk         = 1'b0;
    Reset       = 1'b1;
    Hold        = 1'b0;
    seed        = 32'h9f8c;
    errorCount  = 0;
    passedTests = 0;
    clearProgram();
    testResetState();
    testImmediate();
    testRegisterShifts();
    testFlags();
    testHold();
    testPcAndUnsupported();
    $display("%0d of %0d tests passed, %0d errors", passedTests, NumTests, errorCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge Clk);
    $display("Watchdog expired after %0d cycles before the tests finished", WatchdogCycles);
    $display("Test failed");
    $finish;
  end

endmodule

// File: sim/armCore_chk.sv
/* Concurrent assertions on the core's top-level ports, bound to armCore */
module armCoreChk
  import armPkg::*;
(
  input logic    Clk,
  input logic    Reset,
  input logic    Hold,
  input dataT    InstrAddr,
  input logic    WbEnable,
  input regAddrT WbReg
);

  wbIdleAfterReset: assert property (@(posedge Clk) $fell(Reset) |-> !WbEnable)
    else $error("write-back enabled on the first edge after reset");

  noPcWrite: assert property (@(posedge Clk) disable iff (Reset)
    WbEnable |-> WbReg != PcReg)
    else $error("write-back targets register 15");

  fetchHeld: assert property (@(posedge Clk) disable iff (Reset)
    Hold |=> $stable(InstrAddr))
    else $error("InstrAddr moved while Hold was high");

  // Fetch steps one word per free cycle
  fetchAdvance: assert property (@(posedge Clk) disable iff (Reset)
    !Hold |=> InstrAddr == $past(InstrAddr) + 32'd4)
    else $error("InstrAddr did not advance by 4");

endmodule

bind armCore armCoreChk armCoreChk_i (.*);

// File: src/armCore.sv
/* Top level of the five-stage core: fetch, decode and execute stages */
module armCore
  import armPkg::*;
#(
  parameter dataT ResetAddr = '0
) (
  input  logic    Clk,
  input  logic    Reset,
  input  logic    Hold,
  output dataT    InstrAddr,
  input  dataT    Instr,
  output logic    WbEnable,
  output regAddrT WbReg,
  output dataT    WbData,
  output flagsT   Flags
);

  dataT        idInstr;
  dataT        idPc;
  dataT        exOperandA;
  dataT        exRm;
  logic [11:0] exImm;
  operandModeT exMode;
  shiftTypeT   exShiftType;
  aluOpT       exAluOp;
  regAddrT     exRd;
  logic        exWrite;
  logic        exSetFlags;

  fetchStage #(
    .ResetAddr(ResetAddr)
  ) fetchStage_i (
    .Clk      (Clk),
    .Reset    (Reset),
    .Hold     (Hold),
    .Instr    (Instr),
    .InstrAddr(InstrAddr),
    .IdInstr  (idInstr),
    .IdPc     (idPc)
  );

  decodeStage decodeStage_i (
    .Clk        (Clk),
    .Reset      (Reset),
    .Hold       (Hold),
    .IdInstr    (idInstr),
    .IdPc       (idPc),
    .WbEnable   (WbEnable),   // Write-back loops into register file
    .WbReg      (WbReg),
    .WbData     (WbData),
    .ExOperandA (exOperandA),
    .ExRm       (exRm),
    .ExImm      (exImm),
    .ExMode     (exMode),
    .ExShiftType(exShiftType),
    .ExAluOp    (exAluOp),
    .ExRd       (exRd),
    .ExWrite    (exWrite),
    .ExSetFlags (exSetFlags)
  );

  executeStage executeStage_i (
    .Clk        (Clk),
    .Reset      (Reset),
    .ExOperandA (exOperandA),
    .ExRm       (exRm),
    .ExImm      (exImm),
    .ExMode     (exMode),
    .ExShiftType(exShiftType),
    .ExAluOp    (exAluOp),
    .ExRd       (exRd),
    .ExWrite    (exWrite),
    .ExSetFlags (exSetFlags),
    .WbEnable   (WbEnable),
    .WbReg      (WbReg),
    .WbData     (WbData),
    .Flags      (Flags)
  );

endmodule

// File: src/fetchStage.sv
/* Program counter and fetch/decode pipeline register */
module fetchStage
  import armPkg::*;
#(
  parameter dataT ResetAddr = '0
) (
  input  logic Clk,
  input  logic Reset,
  input  logic Hold,
  input  dataT Instr,
  output dataT InstrAddr,
  output dataT IdInstr,
  output dataT IdPc
);

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      InstrAddr <= ResetAddr;
      IdInstr   <= NopInstr;      // Decode starts on a bubble
      IdPc      <= '0;
    end else if (!Hold) begin
      InstrAddr <= InstrAddr + 32'd4;
      IdInstr   <= Instr;         // Instruction returns in the same cycle
      IdPc      <= InstrAddr;     // Address that fetched it
    end
  end

endmodule

// File: verilog.f
common/armPkg.sv
execute/barrelShifter.sv
execute/aluFlags.sv
execute/executeStage.sv
decode/controlDecoder.sv
decode/registerFile.sv
decode/decodeStage.sv
src/fetchStage.sv
src/armCore.sv
sim/armCore_chk.sv
sim/armCoreTb.sv
